// ==== files.f ====
logic/core_cfg_pkg.sv
logic/isa_ops_pkg.sv
logic/alu_unit.sv
logic/mul_unit.sv
logic/cdb_arbiter.sv
logic/exec_cluster.sv
verif/exec_cluster_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# build and run the exec_cluster testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module exec_cluster_tb -f files.f -o exec_sim \
    && ./obj_dir/exec_sim > sim.log 2>&1
cat sim.log 2>/dev/null

grep -qF "*** TEST PASSED ***" sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== verif/exec_cluster_tb.sv ====
module exec_cluster_tb
    import core_cfg_pkg::*;
    import isa_ops_pkg::*;
();

    localparam int max_entries = 32;
    localparam logic [opcode_bits-1:0] opc_alu = {6'h00, 6'h20};

    logic                   clk = 1'b0;
    logic                   rst = 1'b1;
    logic                   alu_issue = 1'b0;
    logic [tag_bits-1:0]    alu_tag = '0;
    logic [opcode_bits-1:0] alu_opcode = '0;
    alu_op_t                alu_op = op_add;
    logic [data_width-1:0]  alu_a = '0;
    logic [data_width-1:0]  alu_b = '0;
    logic                   alu_free;
    logic                   mul_issue = 1'b0;
    logic [tag_bits-1:0]    mul_tag = '0;
    logic [opcode_bits-1:0] mul_opcode = '0;
    logic [data_width-1:0]  mul_a = '0;
    logic [data_width-1:0]  mul_b = '0;
    logic                   mul_free;
    logic                   cdb_valid;
    logic [tag_bits-1:0]    cdb_tag;
    logic [data_width-1:0]  cdb_result;
    logic [opcode_bits-1:0] cdb_opcode;
    logic                   cdb_branch_taken;

    // the tag of a table entry is its index
    unit_sel_t              t_unit [max_entries];
    logic [opcode_bits-1:0] t_opc  [max_entries];
    alu_op_t                t_op   [max_entries];
    logic [data_width-1:0]  t_a    [max_entries];
    logic [data_width-1:0]  t_b    [max_entries];
    logic [data_width-1:0]  t_exp  [max_entries];
    logic                   t_br   [max_entries];
    int                     t_gap  [max_entries];
    bit                     t_pair [max_entries];
    int                     t_lat  [max_entries];

    bit                     pending   [max_entries];
    bit                     seen      [max_entries];
    int                     issue_cyc [max_entries];
    int                     n = 0;
    int                     errors = 0;
    int                     missing = 0;
    int                     cyc = 0;
    int                     limit = 0;
    logic [31:0]            lcg_state = 32'd99214;
    logic [data_width-1:0]  ra;
    logic [data_width-1:0]  rb;

    exec_cluster DUT (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [data_width-1:0] ref_alu(alu_op_t op, logic [data_width-1:0] a,
                                                       logic [data_width-1:0] b);
        case (op)
            op_add: return a + b;
            op_sub: return a - b;
            op_and: return a & b;
            op_or:  return a | b;
            op_xor: return a ^ b;
            op_nor: return ~(a | b);
            // every bit shifted out once b reaches the width
            op_sll: return (b >= 32'(data_width)) ? '0 : a << b;
            op_srl: return (b >= 32'(data_width)) ? '0 : a >> b;
            op_slt: return ($signed(a) < $signed(b)) ? data_width'(1) : '0;
            op_sgt: return ($signed(a) > $signed(b)) ? data_width'(1) : '0;
            default: return '0;
        endcase
    endfunction

    function automatic logic [data_width-1:0] ref_mul(logic [opcode_bits-1:0] opc,
                                                       logic [data_width-1:0] a,
                                                       logic [data_width-1:0] b);
        logic [2*data_width-1:0] p;
        p = {{data_width{1'b0}}, a} * {{data_width{1'b0}}, b};
        return (opc == opc_mulhu) ? p[2*data_width-1:data_width] : p[data_width-1:0];
    endfunction

    task automatic add_entry(unit_sel_t u, logic [opcode_bits-1:0] opc, alu_op_t op,
                             logic [data_width-1:0] a, logic [data_width-1:0] b,
                             int gap, bit pair, int lat);
        t_unit[n] = u;
        t_opc[n]  = opc;
        t_op[n]   = op;
        t_a[n]    = a;
        t_b[n]    = b;
        t_exp[n]  = (u == unit_mul) ? ref_mul(opc, a, b) : ref_alu(op, a, b);
        // only ALU results carry a taken branch
        t_br[n]   = (u == unit_alu) && (((opc == opc_beq) && (a == b)) ||
                                        ((opc == opc_bne) && (a != b)));
        t_gap[n]  = gap;
        t_pair[n] = pair;
        t_lat[n]  = lat;
        n++;
    endtask

    task automatic check(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    function automatic logic unit_free(int i);
        return (t_unit[i] == unit_mul) ? mul_free : alu_free;
    endfunction

    function automatic int count_missing();
        int c;
        c = 0;
        for (int t = 0; t < n; t++) begin
            if (pending[t]) c++;
        end
        return c;
    endfunction

    task automatic load_entry(int i);
        // the op is taken on the next rising edge
        issue_cyc[i] = cyc;
        pending[i] = 1'b1;
        if (t_unit[i] == unit_mul) begin
            mul_issue  = 1'b1;
            mul_tag    = tag_bits'(i);
            mul_opcode = t_opc[i];
            mul_a      = t_a[i];
            mul_b      = t_b[i];
        end else begin
            alu_issue  = 1'b1;
            alu_tag    = tag_bits'(i);
            alu_opcode = t_opc[i];
            alu_op     = t_op[i];
            alu_a      = t_a[i];
            alu_b      = t_b[i];
        end
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= limit) begin
            $display("timeout after %0d cycles, %0d results never arrived", cyc, count_missing());
            $display("errors: %0d, missing results: %0d", errors, count_missing());
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // scoreboard samples the CDB mid-cycle
    always @(negedge clk) begin
        if (!rst && cdb_valid) begin
            if (pending[cdb_tag]) begin
                pending[cdb_tag] = 1'b0;
                seen[cdb_tag] = 1'b1;
                check("cdb_result", 64'(cdb_result), 64'(t_exp[cdb_tag]));
                check("cdb_branch_taken", 64'(cdb_branch_taken), 64'(t_br[cdb_tag]));
                check("cdb_opcode", 64'(cdb_opcode), 64'(t_opc[cdb_tag]));
                if (t_lat[cdb_tag] != 0) begin
                    check("cdb latency", 64'(cyc - issue_cyc[cdb_tag]), 64'(t_lat[cdb_tag]));
                end
            end else if (seen[cdb_tag]) begin
                $display("tag %0d appeared on the CDB a second time at t=%0t", cdb_tag, $time);
                errors++;
            end else begin
                $display("unknown tag %0d appeared on the CDB at t=%0t", cdb_tag, $time);
                errors++;
            end
        end
    end

    initial begin
        // isolated add and then the remaining ops back to back
        add_entry(unit_alu, opc_alu, op_add, 32'd5, 32'd7, 1, 1'b0, 2);
        add_entry(unit_alu, opc_alu, op_sub, 32'd3, 32'd10, 0, 1'b0, 0);
        add_entry(unit_alu, opc_alu, op_and, 32'hf0f0_1234, 32'h0ff0_ff00, 0, 1'b0, 0);
        add_entry(unit_alu, opc_alu, op_or, 32'hf000_0001, 32'h0000_0f10, 0, 1'b0, 0);
        add_entry(unit_alu, opc_alu, op_xor, 32'haaaa_5555, 32'hffff_0000, 0, 1'b0, 0);
        add_entry(unit_alu, opc_alu, op_nor, 32'h1234_0000, 32'h0000_00ff, 0, 1'b0, 0);
        add_entry(unit_alu, opc_alu, op_sll, 32'h0000_0001, 32'd40, 0, 1'b0, 0);
        add_entry(unit_alu, opc_alu, op_sll, 32'h0000_00ff, 32'd4, 0, 1'b0, 0);
        add_entry(unit_alu, opc_alu, op_srl, 32'h8000_0000, 32'd33, 0, 1'b0, 0);
        add_entry(unit_alu, opc_alu, op_srl, 32'hf000_0000, 32'd28, 0, 1'b0, 0);
        add_entry(unit_alu, opc_alu, op_slt, 32'hffff_fffb, 32'd3, 0, 1'b0, 0);
        add_entry(unit_alu, opc_alu, op_sgt, 32'hffff_fffb, 32'd3, 0, 1'b0, 0);
        add_entry(unit_alu, opc_alu, op_sgt, 32'd7, 32'hffff_ffff, 0, 1'b0, 0);
        add_entry(unit_alu, opc_beq, op_sub, 32'd42, 32'd42, 0, 1'b0, 0);
        add_entry(unit_alu, opc_beq, op_sub, 32'd42, 32'd41, 0, 1'b0, 0);
        add_entry(unit_alu, opc_bne, op_sub, 32'd9, 32'd9, 0, 1'b0, 0);
        add_entry(unit_alu, opc_bne, op_sub, 32'd9, 32'd8, 0, 1'b0, 0);
        ra = lcg_next();
        rb = lcg_next();
        add_entry(unit_mul, opc_mul, op_add, ra, rb, 8, 1'b0, mul_stages_default + 1);
        // consecutive multiplies keep several in flight
        for (int k = 0; k < 4; k++) begin
            ra = lcg_next();
            rb = lcg_next();
            add_entry(unit_mul, k[0] ? opc_mulhu : opc_mul, op_add, ra, rb,
                      (k == 0) ? 6 : 0, 1'b0, 0);
        end
        add_entry(unit_mul, opc_beq, op_add, 32'd77, 32'd77, 0, 1'b0, 0);
        // both units reach the CDB on the same cycle
        add_entry(unit_mul, opc_mulhu, op_add, 32'hffff_ffff, 32'hffff_ffff, 6, 1'b0, 0);
        add_entry(unit_alu, opc_bne, op_xor, 32'd1, 32'd2, 1, 1'b0, 0);
        for (int k = 0; k < 3; k++) begin
            ra = lcg_next();
            rb = lcg_next();
            add_entry(unit_alu, opc_alu, op_add, ra, rb, (k == 0) ? 6 : 0, 1'b1, 0);
            add_entry(unit_mul, opc_mulhu, op_add, rb, ra, 0, 1'b0, 0);
        end
        limit = 20 * n + 50;

        repeat (3) @(negedge clk);
        rst = 1'b0;
        check("cdb_valid after reset", 64'(cdb_valid), 64'd0);
        check("alu_free after reset", 64'(alu_free), 64'd1);
        check("mul_free after reset", 64'(mul_free), 64'd1);

        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            alu_issue = 1'b0;
            mul_issue = 1'b0;
            repeat (t_gap[i]) @(negedge clk);
            // a pipelined multiplier takes a new op every cycle
            if (i > 0 && t_gap[i] == 0 && t_unit[i] == unit_mul) begin
                if (t_unit[i-1] == unit_mul) begin
                    check("mul_free", 64'(mul_free), 64'd1);
                end
            end
            while (!unit_free(i) || (t_pair[i] && !mul_free)) @(negedge clk);
            load_entry(i);
            if (t_pair[i]) begin
                i++;
                load_entry(i);
            end
        end
        @(negedge clk);
        alu_issue = 1'b0;
        mul_issue = 1'b0;

        for (int k = 0; k < 40 && count_missing() > 0; k++) @(negedge clk);
        // a few more cycles to catch repeated tags
        repeat (4) @(negedge clk);
        for (int t = 0; t < n; t++) begin
            if (pending[t]) begin
                $display("tag %0d never appeared on the CDB", t);
                missing++;
            end
        end
        $display("errors: %0d, missing results: %0d", errors, missing);
        if (errors == 0 && missing == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== logic/exec_cluster.sv ====
module exec_cluster
    import core_cfg_pkg::*;
    import isa_ops_pkg::*;
#(
    parameter int data_w     = data_width,
    parameter int tag_w      = tag_bits,
    parameter int mul_stages = mul_stages_default
) (
    input  logic                   clk,
    input  logic                   rst,
    // ALU issue port
    input  logic                   alu_issue,
    input  logic [tag_w-1:0]       alu_tag,
    input  logic [opcode_bits-1:0] alu_opcode,
    input  alu_op_t                alu_op,
    input  logic [data_w-1:0]      alu_a,
    input  logic [data_w-1:0]      alu_b,
    output logic                   alu_free,
    // multiplier issue port
    input  logic                   mul_issue,
    input  logic [tag_w-1:0]       mul_tag,
    input  logic [opcode_bits-1:0] mul_opcode,
    input  logic [data_w-1:0]      mul_a,
    input  logic [data_w-1:0]      mul_b,
    output logic                   mul_free,
    // common data bus
    output logic                   cdb_valid,
    output logic [tag_w-1:0]       cdb_tag,
    output logic [data_w-1:0]      cdb_result,
    output logic [opcode_bits-1:0] cdb_opcode,
    output logic                   cdb_branch_taken
);

    logic                   alu_req;
    logic                   alu_grant;
    logic [tag_w-1:0]       alu_res_tag;
    logic [data_w-1:0]      alu_res_value;
    logic [opcode_bits-1:0] alu_res_opcode;
    logic                   alu_res_branch;
    logic                   mul_req;
    logic                   mul_grant;
    logic [tag_w-1:0]       mul_res_tag;
    logic [data_w-1:0]      mul_res_value;
    logic [opcode_bits-1:0] mul_res_opcode;

    alu_unit #(
        .data_w(data_w),
        .tag_w (tag_w)
    ) u_alu (
        .clk             (clk),
        .rst             (rst),
        .issue           (alu_issue),
        .tag             (alu_tag),
        .opcode          (alu_opcode),
        .op              (alu_op),
        .a               (alu_a),
        .b               (alu_b),
        .grant           (alu_grant),
        .free            (alu_free),
        .req             (alu_req),
        .res_tag         (alu_res_tag),
        .res_value       (alu_res_value),
        .res_opcode      (alu_res_opcode),
        .res_branch_taken(alu_res_branch)
    );

    mul_unit #(
        .data_w(data_w),
        .tag_w (tag_w),
        .stages(mul_stages)
    ) u_mul (
        .clk       (clk),
        .rst       (rst),
        .issue     (mul_issue),
        .tag       (mul_tag),
        .opcode    (mul_opcode),
        .a         (mul_a),
        .b         (mul_b),
        .grant     (mul_grant),
        .free      (mul_free),
        .req       (mul_req),
        .res_tag   (mul_res_tag),
        .res_value (mul_res_value),
        .res_opcode(mul_res_opcode)
    );

    cdb_arbiter #(
        .data_w(data_w),
        .tag_w (tag_w)
    ) u_arb (
        .clk             (clk),
        .rst             (rst),
        .alu_req         (alu_req),
        .alu_tag         (alu_res_tag),
        .alu_value       (alu_res_value),
        .alu_opcode      (alu_res_opcode),
        .alu_branch_taken(alu_res_branch),
        .mul_req         (mul_req),
        .mul_tag         (mul_res_tag),
        .mul_value       (mul_res_value),
        .mul_opcode      (mul_res_opcode),
        .alu_grant       (alu_grant),
        .mul_grant       (mul_grant),
        .cdb_valid       (cdb_valid),
        .cdb_tag         (cdb_tag),
        .cdb_result      (cdb_result),
        .cdb_opcode      (cdb_opcode),
        .cdb_branch_taken(cdb_branch_taken)
    );

endmodule

// ==== logic/cdb_arbiter.sv ====
module cdb_arbiter
    import core_cfg_pkg::*;
    import isa_ops_pkg::*;
#(
    parameter int data_w = data_width,
    parameter int tag_w  = tag_bits
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   alu_req,
    input  logic [tag_w-1:0]       alu_tag,
    input  logic [data_w-1:0]      alu_value,
    input  logic [opcode_bits-1:0] alu_opcode,
    input  logic                   alu_branch_taken,
    input  logic                   mul_req,
    input  logic [tag_w-1:0]       mul_tag,
    input  logic [data_w-1:0]      mul_value,
    input  logic [opcode_bits-1:0] mul_opcode,
    output logic                   alu_grant,
    output logic                   mul_grant,
    output logic                   cdb_valid,
    output logic [tag_w-1:0]       cdb_tag,
    output logic [data_w-1:0]      cdb_result,
    output logic [opcode_bits-1:0] cdb_opcode,
    output logic                   cdb_branch_taken
);

    // multiplier results are older, it always wins
    assign mul_grant = mul_req;
    assign alu_grant = alu_req && !mul_req;

    always_ff @(posedge clk) begin
        if (rst) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= alu_req || mul_req;
        end
    end

    always_ff @(posedge clk) begin
        if (mul_req) begin
            cdb_tag          <= mul_tag;
            cdb_result       <= mul_value;
            cdb_opcode       <= mul_opcode;
            // multiplies never branch
            cdb_branch_taken <= 1'b0;
        end else if (alu_req) begin
            cdb_tag          <= alu_tag;
            cdb_result       <= alu_value;
            cdb_opcode       <= alu_opcode;
            cdb_branch_taken <= alu_branch_taken;
        end
    end

endmodule

// ==== logic/mul_unit.sv ====
module mul_unit
    import core_cfg_pkg::*;
    import isa_ops_pkg::*;
#(
    parameter int data_w = data_width,
    parameter int tag_w  = tag_bits,
    parameter int stages = mul_stages_default
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   issue,
    input  logic [tag_w-1:0]       tag,
    input  logic [opcode_bits-1:0] opcode,
    input  logic [data_w-1:0]      a,
    input  logic [data_w-1:0]      b,
    input  logic                   grant,
    output logic                   free,
    output logic                   req,
    output logic [tag_w-1:0]       res_tag,
    output logic [data_w-1:0]      res_value,
    output logic [opcode_bits-1:0] res_opcode
);

    localparam int last = stages - 1;

    logic                   stage_valid [stages];
    logic [tag_w-1:0]       stage_tag   [stages];
    logic [opcode_bits-1:0] stage_opc   [stages];
    logic [2*data_w-1:0]    stage_prod  [stages];
    logic [2*data_w-1:0]    full_prod;
    logic                   advance;

    // unsigned double-width product, formed entering stage one
    assign full_prod = (2 * data_w)'(a) * (2 * data_w)'(b);

    // whole pipe moves when the tail is empty or leaving on the CDB
    assign advance = !stage_valid[last] || grant;
    assign free    = advance;
    assign req     = stage_valid[last];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < stages; i++) begin
                stage_valid[i] <= 1'b0;
            end
        end else if (advance) begin
            stage_valid[0] <= issue;
            for (int i = 1; i < stages; i++) begin
                stage_valid[i] <= stage_valid[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            stage_tag[0]  <= tag;
            stage_opc[0]  <= opcode;
            stage_prod[0] <= full_prod;
            for (int i = 1; i < stages; i++) begin
                stage_tag[i]  <= stage_tag[i-1];
                stage_opc[i]  <= stage_opc[i-1];
                stage_prod[i] <= stage_prod[i-1];
            end
        end
    end

    // mulhu wants the upper half, all other opcodes the lower
    assign res_value  = (stage_opc[last] == opc_mulhu) ?
                        stage_prod[last][2*data_w-1:data_w] :
                        stage_prod[last][data_w-1:0];
    assign res_tag    = stage_tag[last];
    assign res_opcode = stage_opc[last];

endmodule

// ==== logic/alu_unit.sv ====
module alu_unit
    import core_cfg_pkg::*;
    import isa_ops_pkg::*;
#(
    parameter int data_w = data_width,
    parameter int tag_w  = tag_bits
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   issue,
    input  logic [tag_w-1:0]       tag,
    input  logic [opcode_bits-1:0] opcode,
    input  alu_op_t                op,
    input  logic [data_w-1:0]      a,
    input  logic [data_w-1:0]      b,
    input  logic                   grant,
    output logic                   free,
    output logic                   req,
    output logic [tag_w-1:0]       res_tag,
    output logic [data_w-1:0]      res_value,
    output logic [opcode_bits-1:0] res_opcode,
    output logic                   res_branch_taken
);

    logic [data_w-1:0] result;
    logic              branch_taken;
    logic              accept;

    always_comb begin
        case (op)
            op_add:  result = a + b;
            op_sub:  result = a - b;
            op_and:  result = a & b;
            op_or:   result = a | b;
            op_xor:  result = a ^ b;
            op_nor:  result = ~(a | b);
            op_sll:  result = a << b;
            op_srl:  result = a >> b;
            op_slt:  result = ($signed(a) < $signed(b)) ? data_w'(1) : '0;
            op_sgt:  result = ($signed(a) > $signed(b)) ? data_w'(1) : '0;
            default: result = '0;
        endcase
    end

    // taken only for beq/bne, everything else falls through
    assign branch_taken = ((opcode == opc_beq) && (a == b)) ||
                          ((opcode == opc_bne) && (a != b));

    // slot frees up in the same cycle it is granted, so back-to-back issue works
    assign free   = !req || grant;
    assign accept = issue && free;

    // hold register valid bit, doubles as the CDB request
    always_ff @(posedge clk) begin
        if (rst) begin
            req <= 1'b0;
        end else if (accept) begin
            req <= 1'b1;
        end else if (grant) begin
            req <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            res_tag          <= tag;
            res_value        <= result;
            res_opcode       <= opcode;
            res_branch_taken <= branch_taken;
        end
    end

endmodule

// ==== logic/isa_ops_pkg.sv ====
package isa_ops_pkg;

    // instruction opcode field, primary opcode in the upper six bits
    // and function code in the lower six
    localparam int opcode_bits = 12;

    // ALU operation select, driven by decode
    typedef enum logic [3:0] {
        op_add = 4'b0000,
        op_sub = 4'b0001,
        op_and = 4'b0010,
        op_or  = 4'b0011,
        op_xor = 4'b0100,
        op_nor = 4'b0101,
        // a shifted by b places
        op_sll = 4'b0110,
        op_srl = 4'b0111,
        // signed compares, result is 1 or 0
        op_slt = 4'b1000,
        op_sgt = 4'b1001
    } alu_op_t;

    // branch opcodes
    localparam logic [opcode_bits-1:0] opc_beq = {6'h04, 6'h00};
    localparam logic [opcode_bits-1:0] opc_bne = {6'h05, 6'h00};

    // multiply opcodes, R-type with function code
    localparam logic [opcode_bits-1:0] opc_mul   = {6'h00, 6'h18};
    localparam logic [opcode_bits-1:0] opc_mulhu = {6'h00, 6'h19};

    // which functional unit an operation goes to
    typedef enum logic {
        unit_alu = 1'b0,
        unit_mul = 1'b1
    } unit_sel_t;

endpackage

// ==== logic/core_cfg_pkg.sv ====
package core_cfg_pkg;

    // operand and result width of both functional units
    localparam int data_width = 32;

    // reorder buffer tag, 16 entries plus one extra bit
    localparam int rob_entry_bits = 4;
    localparam int tag_bits = rob_entry_bits + 1;

    // depth of the multiplier pipeline, issue to CDB request
    localparam int mul_stages_default = 3;

endpackage
